/* design/pool_pkg.sv */
// Pooling subsystem shared types and default sizing values
`default_nettype none

package pool_pkg;

    // ========================================================================
    // Fixed-width types
    // ========================================================================

    // One signed activation element
    typedef logic signed [7:0] act_t;

    // Window size K, legal range 1 to 15
    typedef logic [3:0] pool_k_t;

    // Pooling configuration word, 5 bits total
    typedef struct packed {
        pool_k_t k;
        logic    relu_clamp;
    } pool_cfg_t;

    // ========================================================================
    // Default sizing for the top level
    // ========================================================================

    // Activations per vector
    parameter int DEFAULT_LANES = 8;

    // Buffer address width, 64 vectors
    parameter int DEFAULT_IDX_WIDTH = 6;

    // log2 of index FIFO depth, 8 entries
    parameter int DEFAULT_FIFO_AWIDTH = 3;

    // Window size after reset, plain pass-through
    parameter pool_k_t RESET_K = 4'd1;

endpackage

`default_nettype wire

/* design/pool_cfg_regs.sv */
// Pooling configuration register, holds K and clamp flag, blocks writes while busy
`timescale 1ns/1ps
`default_nettype none

module pool_cfg_regs (
    input  logic                clk,
    input  logic                reset,
    input  logic                cfg_wr_en,
    input  pool_pkg::pool_cfg_t cfg_wr_data,
    input  logic                busy,
    output pool_pkg::pool_cfg_t cfg
);

    // Write qualifier
    logic wr_accept;

    // Only while idle, and never a zero window
    assign wr_accept = cfg_wr_en && !busy && (cfg_wr_data.k != '0);

    // ========================================================================
    // Config register
    // ========================================================================

    always_ff @(posedge clk) begin
        if (reset) begin
            // Window of one, clamp off
            cfg <= '{k: pool_pkg::RESET_K, relu_clamp: 1'b0};
        end else if (wr_accept) begin
            cfg <= cfg_wr_data;
        end
    end

    // ========================================================================
    // Checks
    // ========================================================================

    // Lane controller counts to k-1, so k must stay legal
    a_k_nonzero: assert property (
        @(posedge clk) disable iff (reset)
        cfg.k != '0
    ) else $error("pool_cfg_regs: window size became zero");

endmodule

`default_nettype wire

/* design/idx_fifo.sv */
// First-word-fall-through FIFO of buffer read indices
`timescale 1ns/1ps
`default_nettype none

module idx_fifo #(
    parameter int IDX_WIDTH   = 6,
    parameter int FIFO_AWIDTH = 3
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 push,
    input  logic [IDX_WIDTH-1:0] push_data,
    input  logic                 pop,
    output logic [IDX_WIDTH-1:0] head,
    output logic                 empty,
    output logic                 full
);

    localparam int DEPTH = 1 << FIFO_AWIDTH;

    // Storage, no reset needed
    logic [IDX_WIDTH-1:0] mem [DEPTH];

    // Circular pointers
    logic [FIFO_AWIDTH-1:0] wr_ptr;
    logic [FIFO_AWIDTH-1:0] rd_ptr;

    // Occupancy, one extra bit to tell full from empty
    logic [FIFO_AWIDTH:0] count;

    // ========================================================================
    // Storage write
    // ========================================================================

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // ========================================================================
    // Pointers and occupancy
    // ========================================================================

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // Simultaneous push and pop leaves count alone
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Head read straight from storage, no read delay
    assign head  = mem[rd_ptr];
    assign empty = (count == '0);
    assign full  = (count == (FIFO_AWIDTH + 1)'(DEPTH));

    // Parent must respect the flags
    a_no_push_full: assert property (
        @(posedge clk) disable iff (reset) push |-> !full
    ) else $error("idx_fifo: push while full");

    a_no_pop_empty: assert property (
        @(posedge clk) disable iff (reset) pop |-> !empty
    ) else $error("idx_fifo: pop while empty");

endmodule

`default_nettype wire

/* design/act_buffer.sv */
// Activation vector memory, host write port and registered ready/valid read port
`timescale 1ns/1ps
`default_nettype none

module act_buffer #(
    parameter int LANES     = 8,
    parameter int IDX_WIDTH = 6
) (
    input  logic                             clk,
    input  logic                             reset,
    // Host write port
    input  logic                             buf_wr_en,
    input  logic [IDX_WIDTH-1:0]             buf_wr_addr,
    input  pool_pkg::act_t [LANES-1:0]       buf_wr_data,
    // Read address link
    input  logic                             addr_valid,
    input  logic [IDX_WIDTH-1:0]             addr,
    output logic                             addr_ready,
    // Feature-map return link
    output logic                             fm_valid,
    output pool_pkg::act_t [LANES-1:0]       fm_data,
    input  logic                             fm_ready
);

    localparam int DEPTH = 1 << IDX_WIDTH;

    // One vector per entry
    pool_pkg::act_t [LANES-1:0] mem [DEPTH];

    // Read handshake
    logic rd_fire;

    // ========================================================================
    // Host write
    // ========================================================================

    always_ff @(posedge clk) begin
        if (buf_wr_en) begin
            mem[buf_wr_addr] <= buf_wr_data;
        end
    end

    // ========================================================================
    // Read path
    // ========================================================================

    // Accept when the output register is empty or draining this cycle
    assign addr_ready = !fm_valid || fm_ready;
    assign rd_fire    = addr_valid && addr_ready;

    // Output valid flag
    always_ff @(posedge clk) begin
        if (reset) begin
            fm_valid <= 1'b0;
        end else if (rd_fire) begin
            fm_valid <= 1'b1;
        end else if (fm_ready) begin
            fm_valid <= 1'b0;
        end
    end

    // Output data, held under back-pressure
    always_ff @(posedge clk) begin
        if (rd_fire) begin
            fm_data <= mem[addr];
        end
    end

    // Requested address must not move while the read port stalls
    a_addr_hold: assert property (
        @(posedge clk) disable iff (reset)
        addr_valid && !addr_ready |=> addr_valid && $stable(addr)
    ) else $error("act_buffer: read address changed while stalled");

endmodule

`default_nettype wire

/* design/pool_compare_core.sv */
// Lane-wise running max over a window of K beats with optional ReLU clamp
`timescale 1ns/1ps
`default_nettype none

module pool_compare_core #(
    parameter int LANES = 8
) (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       relu_clamp,
    // Beat input
    input  logic                       in_valid,
    input  logic                       in_last,
    input  pool_pkg::act_t [LANES-1:0] in_data,
    output logic                       in_ready,
    // Pooled output
    output logic                       out_valid,
    output pool_pkg::act_t [LANES-1:0] out_data,
    input  logic                       out_ready
);

    // Next beat opens a new window
    logic first_beat;

    // Running maximum, payload only
    pool_pkg::act_t [LANES-1:0] run_max;

    // Max including the current beat
    pool_pkg::act_t [LANES-1:0] next_max;

    // Window result after optional clamp
    pool_pkg::act_t [LANES-1:0] pooled;

    logic out_free;
    logic in_fire;

    // ========================================================================
    // Handshake
    // ========================================================================

    // Output register empty or being read this cycle
    assign out_free = !out_valid || out_ready;

    // Stall only a closing beat that has nowhere to go
    assign in_ready = !in_last || out_free;
    assign in_fire  = in_valid && in_ready;

    // ========================================================================
    // Lane datapath
    // ========================================================================

    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            // First beat loads, later beats compare signed
            if (first_beat || ($signed(in_data[i]) > $signed(run_max[i]))) begin
                next_max[i] = in_data[i];
            end else begin
                next_max[i] = run_max[i];
            end
            // Fused ReLU, negatives go to zero
            if (relu_clamp && ($signed(next_max[i]) < 0)) begin
                pooled[i] = '0;
            end else begin
                pooled[i] = next_max[i];
            end
        end
    end

    // ========================================================================
    // Window state
    // ========================================================================

    always_ff @(posedge clk) begin
        if (reset) begin
            first_beat <= 1'b1;
            out_valid  <= 1'b0;
        end else begin
            if (in_fire) begin
                // Closing beat restarts the window
                first_beat <= in_last;
            end
            if (in_fire && in_last) begin
                out_valid <= 1'b1;
            end else if (out_ready) begin
                out_valid <= 1'b0;
            end
        end
    end

    // Accumulator and output register
    always_ff @(posedge clk) begin
        if (in_fire) begin
            run_max <= next_max;
            if (in_last) begin
                out_data <= pooled;
            end
        end
    end

    a_out_hold: assert property (
        @(posedge clk) disable iff (reset)
        out_valid && !out_ready |=> out_valid && $stable(out_data)
    ) else $error("pool_compare_core: output changed under back-pressure");

endmodule

`default_nettype wire

/* design/pool_lane_ctrl.sv */
// Pooling lane controller, queues indices, issues reads, counts window beats
`timescale 1ns/1ps
`default_nettype none

module pool_lane_ctrl #(
    parameter int LANES       = 8,
    parameter int IDX_WIDTH   = 6,
    parameter int FIFO_AWIDTH = 3
) (
    input  logic                       clk,
    input  logic                       reset,
    input  pool_pkg::pool_cfg_t        cfg,
    // Index stream from host
    input  logic                       idx_valid,
    input  logic [IDX_WIDTH-1:0]       idx,
    output logic                       idx_ready,
    // Read address toward buffer
    output logic                       addr_valid,
    output logic [IDX_WIDTH-1:0]       addr,
    input  logic                       addr_ready,
    // Feature-map beats from buffer
    input  logic                       fm_valid,
    input  pool_pkg::act_t [LANES-1:0] fm_data,
    output logic                       fm_ready,
    // Pooled output
    output logic                       out_valid,
    output pool_pkg::act_t [LANES-1:0] out_data,
    input  logic                       out_ready,
    // Window in progress
    output logic                       busy
);

    // FIFO controls and flags
    logic fifo_push;
    logic fifo_pop;
    logic fifo_empty;
    logic fifo_full;

    // Beat counter within the window
    pool_pkg::pool_k_t beat_cnt;
    pool_pkg::pool_k_t last_beat;
    logic              beat_last;
    logic              fm_fire;

    // ========================================================================
    // Address generation
    // ========================================================================

    assign idx_ready  = !fifo_full;
    assign fifo_push  = idx_valid && idx_ready;
    assign addr_valid = !fifo_empty;
    assign fifo_pop   = addr_valid && addr_ready;

    idx_fifo #(
        .IDX_WIDTH   (IDX_WIDTH),
        .FIFO_AWIDTH (FIFO_AWIDTH)
    ) u_idx_fifo (
        .clk       (clk),
        .reset     (reset),
        .push      (fifo_push),
        .push_data (idx),
        .pop       (fifo_pop),
        .head      (addr),
        .empty     (fifo_empty),
        .full      (fifo_full)
    );

    // ========================================================================
    // Window beat counter
    // ========================================================================

    assign last_beat = cfg.k - pool_pkg::pool_k_t'(1);
    assign beat_last = (beat_cnt == last_beat);
    assign fm_fire   = fm_valid && fm_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            beat_cnt <= '0;
        end else if (fm_fire) begin
            // Wrap on the K-th beat
            beat_cnt <= beat_last ? '0 : beat_cnt + pool_pkg::pool_k_t'(1);
        end
    end

    // Config block must hold k while a window is open
    a_cnt_in_window: assert property (
        @(posedge clk) disable iff (reset) beat_cnt < cfg.k
    ) else $error("pool_lane_ctrl: beat count outside window");

    // Anything queued, partial, in the read register or unread
    assign busy = !fifo_empty || (beat_cnt != '0) || fm_valid || out_valid;

    // ========================================================================
    // Compare core
    // ========================================================================

    pool_compare_core #(
        .LANES (LANES)
    ) u_compare_core (
        .clk        (clk),
        .reset      (reset),
        .relu_clamp (cfg.relu_clamp),
        .in_valid   (fm_valid),
        .in_last    (beat_last),
        .in_data    (fm_data),
        .in_ready   (fm_ready),
        .out_valid  (out_valid),
        .out_data   (out_data),
        .out_ready  (out_ready)
    );

endmodule

`default_nettype wire

/* design/pool_top.sv */
// Pooling subsystem top, config block, lane controller and activation buffer
`timescale 1ns/1ps
`default_nettype none

module pool_top #(
    parameter int LANES       = pool_pkg::DEFAULT_LANES,
    parameter int IDX_WIDTH   = pool_pkg::DEFAULT_IDX_WIDTH,
    parameter int FIFO_AWIDTH = pool_pkg::DEFAULT_FIFO_AWIDTH
) (
    input  logic                       clk,
    input  logic                       reset,
    // Buffer load
    input  logic                       buf_wr_en,
    input  logic [IDX_WIDTH-1:0]       buf_wr_addr,
    input  pool_pkg::act_t [LANES-1:0] buf_wr_data,
    // Configuration
    input  logic                       cfg_wr_en,
    input  pool_pkg::pool_cfg_t        cfg_wr_data,
    output pool_pkg::pool_cfg_t        cfg,
    // Index stream
    input  logic                       idx_valid,
    input  logic [IDX_WIDTH-1:0]       idx,
    output logic                       idx_ready,
    // Pooled output
    output logic                       out_valid,
    output pool_pkg::act_t [LANES-1:0] out_data,
    input  logic                       out_ready
);

    // Controller to buffer links
    logic                       busy;
    logic                       addr_valid;
    logic [IDX_WIDTH-1:0]       addr;
    logic                       addr_ready;
    logic                       fm_valid;
    pool_pkg::act_t [LANES-1:0] fm_data;
    logic                       fm_ready;

    pool_cfg_regs u_cfg_regs (
        .clk         (clk),
        .reset       (reset),
        .cfg_wr_en   (cfg_wr_en),
        .cfg_wr_data (cfg_wr_data),
        .busy        (busy),
        .cfg         (cfg)
    );

    pool_lane_ctrl #(
        .LANES       (LANES),
        .IDX_WIDTH   (IDX_WIDTH),
        .FIFO_AWIDTH (FIFO_AWIDTH)
    ) u_lane_ctrl (
        .clk        (clk),
        .reset      (reset),
        .cfg        (cfg),
        .idx_valid  (idx_valid),
        .idx        (idx),
        .idx_ready  (idx_ready),
        .addr_valid (addr_valid),
        .addr       (addr),
        .addr_ready (addr_ready),
        .fm_valid   (fm_valid),
        .fm_data    (fm_data),
        .fm_ready   (fm_ready),
        .out_valid  (out_valid),
        .out_data   (out_data),
        .out_ready  (out_ready),
        .busy       (busy)
    );

    act_buffer #(
        .LANES     (LANES),
        .IDX_WIDTH (IDX_WIDTH)
    ) u_act_buffer (
        .clk         (clk),
        .reset       (reset),
        .buf_wr_en   (buf_wr_en),
        .buf_wr_addr (buf_wr_addr),
        .buf_wr_data (buf_wr_data),
        .addr_valid  (addr_valid),
        .addr        (addr),
        .addr_ready  (addr_ready),
        .fm_valid    (fm_valid),
        .fm_data     (fm_data),
        .fm_ready    (fm_ready)
    );

endmodule

`default_nettype wire

/* verif/pool_tb.sv */
// Pooling subsystem testbench, random windows checked against a max-pool model
`timescale 1ns/1ps
`default_nettype none

module pool_tb;

    localparam int LANES       = pool_pkg::DEFAULT_LANES;
    localparam int IDX_WIDTH   = pool_pkg::DEFAULT_IDX_WIDTH;
    localparam int FIFO_AWIDTH = pool_pkg::DEFAULT_FIFO_AWIDTH;
    localparam int BUF_DEPTH   = 1 << IDX_WIDTH;

    // Test lengths, in indices or windows
    localparam int T1_IDX     = 16;
    localparam int T2_IDX     = 4;
    localparam int NWIN       = 8;
    localparam int BP_WIN     = 12;
    localparam int TOTAL_IDX  = T1_IDX + T2_IDX + 2 * NWIN * (2 + 3 + 4) + BP_WIN * 3;
    localparam int TIMEOUT_CYCLES = 20 * TOTAL_IDX + 500;

    typedef logic [IDX_WIDTH-1:0]       idx_t;
    typedef pool_pkg::act_t [LANES-1:0] vec_t;

    // DUT ports
    logic                clk;
    logic                reset;
    logic                buf_wr_en;
    idx_t                buf_wr_addr;
    vec_t                buf_wr_data;
    logic                cfg_wr_en;
    pool_pkg::pool_cfg_t cfg_wr_data;
    pool_pkg::pool_cfg_t cfg;
    logic                idx_valid;
    idx_t                idx;
    logic                idx_ready;
    logic                out_valid;
    vec_t                out_data;
    logic                out_ready;

    // Model state
    vec_t  buf_model [BUF_DEPTH];
    idx_t  stream_q[$];
    vec_t  exp_q[$];

    // Bookkeeping
    int    seed = 84;
    int    bp_seed;
    int    errors = 0;
    int    checks = 0;
    int    err_start;
    int    tests_run = 0;
    int    tests_failed = 0;
    int    cycle_cnt = 0;
    logic  saw_idx_stall;
    string cur_test = "startup";

    pool_top #(
        .LANES       (LANES),
        .IDX_WIDTH   (IDX_WIDTH),
        .FIFO_AWIDTH (FIFO_AWIDTH)
    ) pool_top_i (
        .clk         (clk),
        .reset       (reset),
        .buf_wr_en   (buf_wr_en),
        .buf_wr_addr (buf_wr_addr),
        .buf_wr_data (buf_wr_data),
        .cfg_wr_en   (cfg_wr_en),
        .cfg_wr_data (cfg_wr_data),
        .cfg         (cfg),
        .idx_valid   (idx_valid),
        .idx         (idx),
        .idx_ready   (idx_ready),
        .out_valid   (out_valid),
        .out_data    (out_data),
        .out_ready   (out_ready)
    );

    // 10 ns clock
    initial clk = 1'b0;
    always #5 clk = ~clk;

    // ========================================================================
    // Compare tasks and model
    // ========================================================================

    task automatic check_vec(input string name, input vec_t exp, input vec_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("FAIL %s: expected %h, got %h", name, exp, act);
        end
    endtask

    task automatic check_cfg(input string name, input pool_pkg::pool_cfg_t exp,
                             input pool_pkg::pool_cfg_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("FAIL %s: expected k=%0d clamp=%0b, got k=%0d clamp=%0b",
                     name, exp.k, exp.relu_clamp, act.k, act.relu_clamp);
        end
    endtask

    function automatic pool_pkg::pool_cfg_t make_cfg(input int k, input logic clamp);
        pool_pkg::pool_cfg_t c;
        c.k          = pool_pkg::pool_k_t'(k);
        c.relu_clamp = clamp;
        return c;
    endfunction

    // Lane-wise signed max over stream_q[first +: k], then optional ReLU
    function automatic vec_t window_max(input int first, input int k, input logic clamp);
        vec_t           r;
        pool_pkg::act_t v;
        r = buf_model[stream_q[first]];
        for (int l = 0; l < LANES; l++) begin
            for (int j = 1; j < k; j++) begin
                v = buf_model[stream_q[first + j]][l];
                if (v > r[l]) begin
                    r[l] = v;
                end
            end
            if (clamp && (r[l] < 0)) begin
                r[l] = '0;
            end
        end
        return r;
    endfunction

    task automatic fill_stream(input int n);
        stream_q.delete();
        for (int i = 0; i < n; i++) begin
            stream_q.push_back(idx_t'($unsigned($random(seed)) % BUF_DEPTH));
        end
    endtask

    // One expected vector per complete window of the stream
    task automatic fill_expected(input int k, input logic clamp);
        for (int w = 0; w < stream_q.size() / k; w++) begin
            exp_q.push_back(window_max(w * k, k, clamp));
        end
    endtask

    // ========================================================================
    // Drivers, all on the falling edge
    // ========================================================================

    // Random buffer image, mostly negative lanes when neg_bias is set
    task automatic load_buffer(input logic neg_bias);
        vec_t v;
        int   r;
        for (int a = 0; a < BUF_DEPTH; a++) begin
            for (int l = 0; l < LANES; l++) begin
                r    = $random(seed);
                v[l] = pool_pkg::act_t'(r[7:0]);
                if (neg_bias && (r[9:8] != 2'b00) && (v[l] >= 0)) begin
                    v[l] = ~v[l];
                end
            end
            @(negedge clk);
            buf_wr_en    = 1'b1;
            buf_wr_addr  = idx_t'(a);
            buf_wr_data  = v;
            buf_model[a] = v;
        end
        @(negedge clk);
        buf_wr_en = 1'b0;
    endtask

    // Called on a falling edge, visible one cycle later
    task automatic write_cfg(input pool_pkg::pool_cfg_t c);
        cfg_wr_en   = 1'b1;
        cfg_wr_data = c;
        @(negedge clk);
        cfg_wr_en   = 1'b0;
    endtask

    // Gaps only between transfers, a stalled index stays put
    task automatic send_stream(input int gap_pct);
        int   i;
        logic held;
        i    = 0;
        held = 1'b0;
        while (i < stream_q.size()) begin
            @(negedge clk);
            if (!held && (gap_pct > 0) && (($unsigned($random(seed)) % 100) < gap_pct)) begin
                idx_valid = 1'b0;
            end else begin
                idx_valid = 1'b1;
                idx       = stream_q[i];
                // idx_ready moves only on a rising edge
                held = !idx_ready;
                if (idx_ready) begin
                    i++;
                end
            end
        end
        @(negedge clk);
        idx_valid = 1'b0;
    endtask

    // Long stall first, then random out_ready until all windows are out
    task automatic drive_backpressure(input int hold_cycles);
        repeat (hold_cycles) begin
            @(negedge clk);
            out_ready = 1'b0;
        end
        while (exp_q.size() != 0) begin
            @(negedge clk);
            out_ready = (($unsigned($random(bp_seed)) % 100) < 60);
        end
        @(negedge clk);
        out_ready = 1'b1;
    endtask

    // Extra idle cycles catch duplicated outputs
    task automatic drain();
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        repeat (8) @(negedge clk);
    endtask

    task automatic run_windows(input int k, input logic clamp, input int nwin);
        fill_stream(nwin * k);
        fill_expected(k, clamp);
        send_stream(0);
        drain();
    endtask

    task automatic begin_test(input string name);
        cur_test  = name;
        err_start = errors;
    endtask

    task automatic end_test();
        tests_run++;
        if (errors == err_start) begin
            $display("test %s: ok", cur_test);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", cur_test, errors - err_start);
        end
    endtask

    // ========================================================================
    // Output monitor and timeout
    // ========================================================================

    // Sampled before the edge updates, both sides stable here
    always @(posedge clk) begin
        if (!reset) begin
            if (!out_ready && !idx_ready) begin
                saw_idx_stall = 1'b1;
            end
            if (out_valid && out_ready) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("ERROR %s: pooled output arrived with none expected", cur_test);
                end else begin
                    check_vec(cur_test, exp_q.pop_front(), out_data);
                end
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt > TIMEOUT_CYCLES) begin
            $display("ERROR timeout after %0d cycles in test %s", cycle_cnt, cur_test);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    // ========================================================================
    // Test sequence
    // ========================================================================

    initial begin
        reset         = 1'b1;
        buf_wr_en     = 1'b0;
        buf_wr_addr   = '0;
        buf_wr_data   = '0;
        cfg_wr_en     = 1'b0;
        cfg_wr_data   = '0;
        idx_valid     = 1'b0;
        idx           = '0;
        out_ready     = 1'b1;
        saw_idx_stall = 1'b0;
        bp_seed       = $random(seed);
        repeat (4) @(negedge clk);
        reset = 1'b0;

        load_buffer(1'b0);

        // K=1 passes each vector straight through
        begin_test("reset_k1");
        check_cfg(cur_test, make_cfg(1, 1'b0), cfg);
        run_windows(1, 1'b0, T1_IDX);
        end_test();

        begin_test("cfg_writes");
        write_cfg(make_cfg(4, 1'b1));
        check_cfg(cur_test, make_cfg(4, 1'b1), cfg);
        // Zero window refused
        write_cfg(make_cfg(0, 1'b0));
        check_cfg(cur_test, make_cfg(4, 1'b1), cfg);
        // Write while a window is in flight
        fill_stream(T2_IDX);
        fill_expected(4, 1'b1);
        send_stream(0);
        write_cfg(make_cfg(2, 1'b0));
        check_cfg(cur_test, make_cfg(4, 1'b1), cfg);
        drain();
        end_test();

        begin_test("max_k2_to_k4");
        for (int k = 2; k <= 4; k++) begin
            write_cfg(make_cfg(k, 1'b0));
            check_cfg(cur_test, make_cfg(k, 1'b0), cfg);
            run_windows(k, 1'b0, NWIN);
        end
        end_test();

        // Mostly negative data so the clamp matters
        load_buffer(1'b1);
        begin_test("relu_clamp");
        for (int k = 2; k <= 4; k++) begin
            write_cfg(make_cfg(k, 1'b1));
            check_cfg(cur_test, make_cfg(k, 1'b1), cfg);
            run_windows(k, 1'b1, NWIN);
        end
        end_test();

        begin_test("backpressure");
        write_cfg(make_cfg(3, 1'b0));
        check_cfg(cur_test, make_cfg(3, 1'b0), cfg);
        fill_stream(BP_WIN * 3);
        fill_expected(3, 1'b0);
        saw_idx_stall = 1'b0;
        fork
            send_stream(30);
            drive_backpressure(40);
        join
        drain();
        if (!saw_idx_stall) begin
            errors++;
            $display("ERROR %s: idx_ready never dropped while out_ready was low", cur_test);
        end
        end_test();

        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sources.f */
design/pool_pkg.sv
design/pool_cfg_regs.sv
design/idx_fifo.sv
design/act_buffer.sv
design/pool_compare_core.sv
design/pool_lane_ctrl.sv
design/pool_top.sv
verif/pool_tb.sv

/* Bender.yml */
package:
  name: pool_subsystem

sources:
  - design/pool_pkg.sv
  - design/pool_cfg_regs.sv
  - design/idx_fifo.sv
  - design/act_buffer.sv
  - design/pool_compare_core.sv
  - design/pool_lane_ctrl.sv
  - design/pool_top.sv
  - target: test
    files:
      - verif/pool_tb.sv
